/* common/link_defines.svh */
`ifndef LINK_DEFINES_SVH
`define LINK_DEFINES_SVH

// ==========================================================================
// link and memory sizes
// ==========================================================================
`define WORD_W          128
`define CODE_W          4
`define CODE_LSB        18      // code field is cmd bits 21..18
`define ROM_ADDR_W      10
`define ROM_DEPTH       1024
`define LEN_W           8
`define CREDIT_MAX      4       // chip buffer depth in words

// interface codes, 8..15 unknown
`define IFCODE_CFG      0
`define IFCODE_FLGOFM   1
`define IFCODE_OFM      2
`define IFCODE_WEIADDR  3
`define IFCODE_WEI      4
`define IFCODE_FLGWEI   5
`define IFCODE_ACT      6
`define IFCODE_FLGACT   7

// words per transfer
`define LEN_CFG         4
`define LEN_WEIADDR     4
`define LEN_FLGWEI      16
`define LEN_WEI         16
`define LEN_FLGACT      16
`define LEN_ACT         16
`define LEN_FLGOFM      4
`define LEN_OFM         4

// transfers held by each region
`define NUMBLK_CFG      1
`define NUMBLK_WEIADDR  2
`define NUMBLK_FLGWEI   2
`define NUMBLK_WEI      4
`define NUMBLK_FLGACT   2
`define NUMBLK_ACT      4
`define NUMBLK_OFM      4

// regions packed back to back from address 0
`define BASE_CFG        0
`define BASE_WEIADDR    (`BASE_CFG + `LEN_CFG * `NUMBLK_CFG)
`define BASE_FLGWEI     (`BASE_WEIADDR + `LEN_WEIADDR * `NUMBLK_WEIADDR)
`define BASE_WEI        (`BASE_FLGWEI + `LEN_FLGWEI * `NUMBLK_FLGWEI)
`define BASE_FLGACT     (`BASE_WEI + `LEN_WEI * `NUMBLK_WEI)
`define BASE_ACT        (`BASE_FLGACT + `LEN_FLGACT * `NUMBLK_FLGACT)
`define BASE_OFM        (`BASE_ACT + `LEN_ACT * `NUMBLK_ACT)
`define BASE_FLGOFM     (`BASE_OFM + `LEN_OFM * `NUMBLK_OFM)

`endif

/* common/link_pkg.sv */
`include "link_defines.svh"

// ==========================================================================
// chip link types
// ==========================================================================
package link_pkg;

    // one word on the data bus, also the command word
    typedef logic [`WORD_W-1:0] word_t;

    // region selector carried in the command
    typedef logic [`CODE_W-1:0] code_t;

endpackage

/* common/region_pkg.sv */
`include "link_defines.svh"

// ==========================================================================
// pattern memory region types
// ==========================================================================
package region_pkg;

    // wraps at the memory depth
    typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;

    // words per transfer, 0 means nothing to send
    typedef logic [`LEN_W-1:0] xfer_len_t;

endpackage

/* region/pattern_rom.sv */
`timescale 1ns/10ps
`include "link_defines.svh"

module pattern_rom (
    input  logic                  clk,
    input  logic                  rd_en,
    input  region_pkg::rom_addr_t rd_addr,
    input  logic                  wr_en,
    input  region_pkg::rom_addr_t wr_addr,
    input  link_pkg::word_t       wr_data,
    output link_pkg::word_t       rd_data
);
    import link_pkg::*;

    word_t mem [0:`ROM_DEPTH-1];

    // load port, filled while the engine is idle
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (rd_en)
            rd_data <= mem[rd_addr];    // one cycle latency
    end

endmodule

/* region/region_table.sv */
`timescale 1ns/10ps
`include "link_defines.svh"

module region_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  link_pkg::code_t       code,
    input  logic                  advance,
    output region_pkg::rom_addr_t base_addr,
    output region_pkg::xfer_len_t xfer_len
);
    import link_pkg::*;
    import region_pkg::*;

    rom_addr_t              base_regs [0:7];
    logic [`CODE_W-2:0]     idx;
    logic                   known;

    assign idx   = code[`CODE_W-2:0];
    assign known = !code[`CODE_W-1];    // codes 8..15 have no region

    assign base_addr = known ? base_regs[idx] : '0;

    always_comb begin
        case (code)
            code_t'(`IFCODE_CFG):     xfer_len = xfer_len_t'(`LEN_CFG);
            code_t'(`IFCODE_FLGOFM):  xfer_len = xfer_len_t'(`LEN_FLGOFM);
            code_t'(`IFCODE_OFM):     xfer_len = xfer_len_t'(`LEN_OFM);
            code_t'(`IFCODE_WEIADDR): xfer_len = xfer_len_t'(`LEN_WEIADDR);
            code_t'(`IFCODE_WEI):     xfer_len = xfer_len_t'(`LEN_WEI);
            code_t'(`IFCODE_FLGWEI):  xfer_len = xfer_len_t'(`LEN_FLGWEI);
            code_t'(`IFCODE_ACT):     xfer_len = xfer_len_t'(`LEN_ACT);
            code_t'(`IFCODE_FLGACT):  xfer_len = xfer_len_t'(`LEN_FLGACT);
            default:                  xfer_len = '0;
        endcase
    end

    // each region walks forward one transfer at a time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_regs[`IFCODE_CFG]     <= rom_addr_t'(`BASE_CFG);
            base_regs[`IFCODE_FLGOFM]  <= rom_addr_t'(`BASE_FLGOFM);
            base_regs[`IFCODE_OFM]     <= rom_addr_t'(`BASE_OFM);
            base_regs[`IFCODE_WEIADDR] <= rom_addr_t'(`BASE_WEIADDR);
            base_regs[`IFCODE_WEI]     <= rom_addr_t'(`BASE_WEI);
            base_regs[`IFCODE_FLGWEI]  <= rom_addr_t'(`BASE_FLGWEI);
            base_regs[`IFCODE_ACT]     <= rom_addr_t'(`BASE_ACT);
            base_regs[`IFCODE_FLGACT]  <= rom_addr_t'(`BASE_FLGACT);
        end else if (advance && known) begin
            base_regs[idx] <= base_regs[idx] + rom_addr_t'(xfer_len);
        end
    end

    // controller skips the stream for unknown codes
    a_advance_known: assert property (@(posedge clk) disable iff (!rst_n)
        advance |-> known);

endmodule

/* link/stream_engine.sv */
`timescale 1ns/10ps
`include "link_defines.svh"

module stream_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  region_pkg::rom_addr_t start_addr,
    input  region_pkg::xfer_len_t start_len,
    input  logic                  credit_return,
    input  link_pkg::word_t       rd_data,
    output logic                  rd_en,
    output region_pkg::rom_addr_t rd_addr,
    output logic                  tx_valid,
    output link_pkg::word_t       tx_data,
    output logic                  cs_n,
    output logic                  done
);
    import region_pkg::*;

    localparam int CREDIT_W = $clog2(`CREDIT_MAX + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_FULL = CREDIT_W'(`CREDIT_MAX);

    xfer_len_t           remaining;
    logic [CREDIT_W-1:0] credits;
    logic                rd_vld_q;  // rd_data valid this cycle
    logic                rd_last_q;

    // ======================================================================
    // read issue
    // ======================================================================
    assign rd_en = (remaining != '0) && (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= '0;
            rd_addr   <= '0;
        end else if (start) begin
            remaining <= start_len;
            rd_addr   <= start_addr;
        end else if (rd_en) begin
            remaining <= remaining - 1'b1;
            rd_addr   <= rd_addr + 1'b1;    // wraps with the memory
        end
    end

    // one credit per read issued, one back per word consumed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CREDIT_FULL;
        end else begin
            case ({rd_en, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // ======================================================================
    // output pipeline
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_q  <= 1'b0;
            rd_last_q <= 1'b0;
            tx_valid  <= 1'b0;
            done      <= 1'b0;
        end else begin
            rd_vld_q  <= rd_en;
            rd_last_q <= rd_en && (remaining == xfer_len_t'(1));
            tx_valid  <= rd_vld_q;
            done      <= rd_vld_q && rd_last_q;   // with the final word
        end
    end

    always_ff @(posedge clk) begin
        if (rd_vld_q)
            tx_data <= rd_data;
    end

    // chip select spans the whole transfer, stalls included
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cs_n <= 1'b1;
        else if (start)
            cs_n <= 1'b0;
        else if (done)
            cs_n <= 1'b1;
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CREDIT_FULL);

    // chip must not return a credit it never got
    a_no_extra_credit: assert property (@(posedge clk) disable iff (!rst_n)
        !(credit_return && (credits == CREDIT_FULL)));

endmodule

/* link/xfer_ctrl.sv */
`timescale 1ns/10ps
`include "link_defines.svh"

module xfer_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  link_pkg::word_t       cmd_data,
    input  region_pkg::xfer_len_t xfer_len,
    input  region_pkg::rom_addr_t base_addr,
    input  logic                  done,
    output logic                  cmd_ready,
    output link_pkg::code_t       code,
    output logic                  advance,
    output logic                  start,
    output region_pkg::rom_addr_t start_addr,
    output region_pkg::xfer_len_t start_len
);
    import link_pkg::*;

    typedef enum logic [1:0] {IDLE, LOOKUP, STREAM, CLOSE} state_t;

    state_t state;
    state_t state_nxt;
    code_t  cmd_code;
    logic   cmd_take;

    assign cmd_code  = cmd_data[`CODE_LSB +: `CODE_W];
    assign cmd_ready = (state == IDLE);
    assign cmd_take  = cmd_valid && cmd_ready;

    // table answers in LOOKUP, engine latches on the next edge
    assign start      = (state == LOOKUP) && (xfer_len != '0);
    assign start_addr = base_addr;
    assign start_len  = xfer_len;
    assign advance    = (state == CLOSE);   // one cycle, then idle

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (cmd_take) state_nxt = LOOKUP;
            LOOKUP:  state_nxt = (xfer_len != '0) ? STREAM : IDLE;  // unknown code skips
            STREAM:  if (done) state_nxt = CLOSE;
            CLOSE:   state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            code  <= '0;
        end else begin
            state <= state_nxt;
            if (cmd_take)
                code <= cmd_code;
        end
    end

    // engine finishes only the transfer it was handed
    a_done_in_stream: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (state == STREAM));

endmodule

/* verilog/host_link_top.sv */
`timescale 1ns/10ps
`include "link_defines.svh"

module host_link_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  link_pkg::word_t       cmd_data,
    input  logic                  credit_return,
    input  logic                  rom_wr_en,
    input  region_pkg::rom_addr_t rom_wr_addr,
    input  link_pkg::word_t       rom_wr_data,
    output logic                  cmd_ready,
    output logic                  tx_valid,
    output link_pkg::word_t       tx_data,
    output logic                  cs_n
);
    import link_pkg::*;
    import region_pkg::*;

    code_t     code;
    rom_addr_t base_addr;
    xfer_len_t xfer_len;
    logic      advance;
    logic      start;
    rom_addr_t start_addr;
    xfer_len_t start_len;
    logic      done;
    logic      rd_en;
    rom_addr_t rd_addr;
    word_t     rd_data;

    xfer_ctrl u_xfer_ctrl (
        .clk(clk), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_data(cmd_data),
        .xfer_len(xfer_len), .base_addr(base_addr), .done(done),
        .cmd_ready(cmd_ready), .code(code), .advance(advance),
        .start(start), .start_addr(start_addr), .start_len(start_len)
    );

    region_table u_region_table (
        .clk(clk), .rst_n(rst_n), .code(code), .advance(advance),
        .base_addr(base_addr), .xfer_len(xfer_len)
    );

    stream_engine u_stream_engine (
        .clk(clk), .rst_n(rst_n),
        .start(start), .start_addr(start_addr), .start_len(start_len),
        .credit_return(credit_return), .rd_data(rd_data),
        .rd_en(rd_en), .rd_addr(rd_addr),
        .tx_valid(tx_valid), .tx_data(tx_data), .cs_n(cs_n), .done(done)
    );

    pattern_rom u_pattern_rom (
        .clk(clk), .rd_en(rd_en), .rd_addr(rd_addr),
        .wr_en(rom_wr_en), .wr_addr(rom_wr_addr), .wr_data(rom_wr_data),
        .rd_data(rd_data)
    );

endmodule

/* test/tb_host_link.sv */
`timescale 1ns/10ps
`include "link_defines.svh"

module tb_host_link;
    import link_pkg::*;
    import region_pkg::*;

    localparam logic [31:0] SEED = 32'd92430;
    localparam int N_RAND = 40;

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    word_t     cmd_data;
    logic      credit_return;
    logic      rom_wr_en;
    rom_addr_t rom_wr_addr;
    word_t     rom_wr_data;
    logic      cmd_ready;
    logic      tx_valid;
    word_t     tx_data;
    logic      cs_n;

    word_t       mirror [0:`ROM_DEPTH-1];   // copy of what was loaded
    int          model_base [0:7];
    word_t       exp_q [$];
    logic [31:0] rng;
    logic [31:0] credit_rng;
    logic        stall_en;                  // withhold credits at random
    int          cmd_words;
    int          words_total;
    int          credits_given;
    int          owed;
    int          hold_cnt;
    int          cycles;
    int          cycle_limit = 1000000;
    logic [3:0]  rand_codes [0:N_RAND-1];
    logic        rand_stall [0:N_RAND-1];

    host_link_top DUT (
        .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_data(cmd_data),
        .credit_return(credit_return), .rom_wr_en(rom_wr_en),
        .rom_wr_addr(rom_wr_addr), .rom_wr_data(rom_wr_data),
        .cmd_ready(cmd_ready), .tx_valid(tx_valid), .tx_data(tx_data), .cs_n(cs_n)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ======================================================================
    // helpers and reference model
    // ======================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int region_len(input logic [3:0] code);
        case (code)
            `IFCODE_CFG:     return `LEN_CFG;
            `IFCODE_FLGOFM:  return `LEN_FLGOFM;
            `IFCODE_OFM:     return `LEN_OFM;
            `IFCODE_WEIADDR: return `LEN_WEIADDR;
            `IFCODE_WEI:     return `LEN_WEI;
            `IFCODE_FLGWEI:  return `LEN_FLGWEI;
            `IFCODE_ACT:     return `LEN_ACT;
            `IFCODE_FLGACT:  return `LEN_FLGACT;
            default:         return 0;      // unknown, nothing sent
        endcase
    endfunction

    // word idx of the next transfer for this code
    function automatic word_t expected_word(input logic [3:0] code, input int idx);
        return mirror[(model_base[code[2:0]] + idx) % `ROM_DEPTH];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    task automatic draw_word(output word_t w);
        for (int i = 0; i < `WORD_W / 32; i++) begin
            rng = xorshift32(rng);
            w[i*32 +: 32] = rng;
        end
    endtask

    task automatic preload_memory();
        word_t w;
        for (int a = 0; a < `ROM_DEPTH; a++) begin
            draw_word(w);
            w[`ROM_ADDR_W-1:0] = w[`ROM_ADDR_W-1:0] ^ a[`ROM_ADDR_W-1:0];
            mirror[a] = w;
            rom_wr_en   = 1'b1;
            rom_wr_addr = rom_addr_t'(a);
            rom_wr_data = w;
            @(negedge clk);
        end
        rom_wr_en = 1'b0;
    endtask

    // one command, waits until the engine is idle again
    task automatic send_cmd(input logic [3:0] code, input logic stall);
        int    len;
        word_t cmd;
        len = region_len(code);
        while (!cmd_ready) @(negedge clk);
        draw_word(cmd);
        cmd[`CODE_LSB +: `CODE_W] = code;
        cmd_valid = 1'b1;
        cmd_data  = cmd;
        @(posedge clk);                     // taken on this edge
        stall_en  = stall;
        cmd_words = 0;
        for (int i = 0; i < len; i++)
            exp_q.push_back(expected_word(code, i));
        @(negedge clk);
        cmd_valid = 1'b0;
        while (!cmd_ready) @(negedge clk);
        check_value("tx word count", 128'(cmd_words), 128'(len));
        check_value("cs_n", cs_n, 1'b1);
        if (!code[3])
            model_base[code[2:0]] = (model_base[code[2:0]] + len) % `ROM_DEPTH;
    endtask

    // ======================================================================
    // stimulus
    // ======================================================================
    initial begin
        int         words;
        logic [2:0] unk_lo;
        logic [2:0] unk_hi;
        rst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd_data = '0;
        rom_wr_en = 1'b0;
        rom_wr_addr = '0;
        rom_wr_data = '0;
        stall_en = 1'b0;
        cmd_words = 0;
        rng = SEED;
        model_base[`IFCODE_CFG]     = `BASE_CFG;
        model_base[`IFCODE_FLGOFM]  = `BASE_FLGOFM;
        model_base[`IFCODE_OFM]     = `BASE_OFM;
        model_base[`IFCODE_WEIADDR] = `BASE_WEIADDR;
        model_base[`IFCODE_WEI]     = `BASE_WEI;
        model_base[`IFCODE_FLGWEI]  = `BASE_FLGWEI;
        model_base[`IFCODE_ACT]     = `BASE_ACT;
        model_base[`IFCODE_FLGACT]  = `BASE_FLGACT;
        // three passes over known codes, two known after the unknowns
        words = 2 * `LEN_WEI;               // no region is longer than WEI
        for (int c = 0; c < 8; c++)
            words += 3 * region_len(4'(c));
        for (int i = 0; i < N_RAND; i++) begin
            rng = xorshift32(rng);
            rand_codes[i] = (rng[5:4] == 2'd0) ? {1'b1, rng[2:0]} : {1'b0, rng[2:0]};
            rand_stall[i] = rng[8];
            words += region_len(rand_codes[i]);
        end
        cycle_limit = (4 + `ROM_DEPTH + words) * 4 + 200;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("cmd_ready", cmd_ready, 1'b1);
        check_value("tx_valid", tx_valid, 1'b0);
        check_value("cs_n", cs_n, 1'b1);

        preload_memory();
        for (int c = 0; c < 8; c++)
            send_cmd(4'(c), 1'b0);
        for (int c = 0; c < 8; c++)
            send_cmd(4'(c), 1'b0);          // continues past the first block
        for (int c = 0; c < 8; c++)
            send_cmd(4'(c), 1'b1);
        rng = xorshift32(rng);
        unk_lo = rng[2:0];
        unk_hi = rng[5:3];
        send_cmd({1'b1, unk_lo}, 1'b0);
        send_cmd({1'b1, unk_hi}, 1'b1);
        send_cmd({1'b0, unk_lo}, 1'b0);     // same region slot as the skipped codes
        send_cmd({1'b0, unk_hi}, 1'b0);
        for (int i = 0; i < N_RAND; i++)
            send_cmd(rand_codes[i], rand_stall[i]);

        repeat (4) @(negedge clk);
        if (exp_q.size() == 0 && cs_n && cmd_ready) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("a transfer is still open at the end of the run");
        end
    end

    // ======================================================================
    // compare and credit return
    // ======================================================================
    initial begin
        word_t exp;
        logic  in_burst;
        credit_return = 1'b0;
        credit_rng = xorshift32(~SEED);
        words_total = 0;
        credits_given = 0;
        owed = 0;
        hold_cnt = 0;
        in_burst = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && tx_valid) begin
                if (exp_q.size() == 0)
                    abort_run("tx_valid went high with no transfer pending");
                exp = exp_q.pop_front();
                check_value("tx_data", tx_data, exp);
                check_value("cs_n", cs_n, 1'b0);
                cmd_words++;
                words_total++;
                owed++;
                in_burst = (exp_q.size() != 0);
                if (words_total > credits_given + `CREDIT_MAX)
                    abort_run("more words were sent than credits allow");
            end else if (in_burst) begin
                check_value("cs_n", cs_n, 1'b0);    // stalled, still selected
            end
            if (hold_cnt > 0) begin
                hold_cnt--;
                credit_return = 1'b0;
            end else if (owed > 0) begin
                credit_rng = xorshift32(credit_rng);
                if (stall_en && credit_rng[2:0] == 3'd0) begin
                    hold_cnt = 1 + int'(credit_rng[5:3]);
                    credit_return = 1'b0;
                end else begin
                    credit_return = 1'b1;
                    owed--;
                    credits_given++;
                end
            end else begin
                credit_return = 1'b0;
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit)
                abort_run($sformatf("timeout, the run did not end in %0d cycles", cycles));
        end
    end

endmodule

/* tb.f */
+incdir+common
common/link_pkg.sv
common/region_pkg.sv
region/pattern_rom.sv
region/region_table.sv
link/stream_engine.sv
link/xfer_ctrl.sv
verilog/host_link_top.sv
test/tb_host_link.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_host_link
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
